// ==== project.f ====
rtl/stream_pkg.sv
rtl/sram_channel_fifo.sv
rtl/alloc_tracker.sv
rtl/latency_bridge.sv
rtl/sram_channel_unit.sv
rtl/sram_controller.sv
verification/sram_controller_checker.sv
verification/tb_sram_controller.sv

// ==== verification/tb_sram_controller.sv ====
// ================================================
// Testbench for the stream buffer controller
// Random traffic, channel model, checks, report
// ================================================

`timescale 1ns/1ps
`default_nettype none

module tb_sram_controller;

    import stream_pkg::*;

    localparam int reset_cycles   = 10;
    localparam int fill_cycles    = 1200;   // Write heavy, channels fill and stall
    localparam int mix_cycles     = 1200;   // Drain heavy
    localparam int settle_allow   = 90;     // Reservation clean-up and flush
    localparam int timeout_cycles = 2 * (reset_cycles + fill_cycles + mix_cycles + settle_allow);

    logic                                     clk;
    logic                                     reset;
    logic                                     wr_valid;
    logic [chan_id_width-1:0]                 wr_id;
    logic [data_width-1:0]                    wr_data;
    logic                                     wr_ready;
    logic                                     alloc_req;
    logic [chan_id_width-1:0]                 alloc_id;
    logic [size_width-1:0]                    alloc_size;
    logic [num_channels-1:0][count_width-1:0] space_free;
    logic [num_channels-1:0]                  drain_req;
    logic [num_channels-1:0][size_width-1:0]  drain_size;
    logic [num_channels-1:0][count_width-1:0] data_avail;
    logic                                     rd_drain;
    logic [chan_id_width-1:0]                 rd_id;
    logic [num_channels-1:0]                  rd_valid;
    logic [data_width-1:0]                    rd_data;

    // ================================================
    // Channel model
    // ================================================
    logic [data_width-1:0] model_q [num_channels][$];
    int     model_stored [num_channels];
    int     model_space_rsv [num_channels];
    int     model_drain_rsv [num_channels];
    int     low_cycles [num_channels];   // Data stored but rd_valid low
    logic   wr_fired;                    // Beat on the bus transfers at the coming edge
    integer seed;
    int     data_errors;
    int     count_errors;
    int     flow_errors;
    int     checker_errors;
    int     cycle_cnt = 0;

    sram_controller dut (.*);

    bind sram_channel_unit sram_controller_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .wr_ready    (wr_ready),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .pop_fire    (pop_fire),
        .fifo_wr_en  (wr_fire),
        .fifo_wr_ptr (u_fifo.wr_ptr),
        .fifo_rd_ptr (u_fifo.rd_ptr),
        .stored_cnt  (u_tracker.stored_cnt),
        .space_free  (space_free),
        .data_avail  (data_avail)
    );

    always #10 clk = ~clk;   // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int model_space(input int c);
        return sram_depth - model_stored[c] - model_space_rsv[c];
    endfunction

    function automatic int model_avail(input int c);
        return model_stored[c] - model_drain_rsv[c];
    endfunction

    function automatic bit reservations_open();
        for (int c = 0; c < num_channels; c++) begin
            if (model_space_rsv[c] != 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Registered outputs against the model, at the falling edge
    task automatic check_outputs();
        for (int c = 0; c < num_channels; c++) begin
            assert (int'(space_free[c]) == model_space(c)) else begin
                $display("error space_free ch %0d: got 0x%0h expected 0x%0h",
                         c, space_free[c], model_space(c));
                count_errors++;
            end
            assert (int'(data_avail[c]) == model_avail(c)) else begin
                $display("error data_avail ch %0d: got 0x%0h expected 0x%0h",
                         c, data_avail[c], model_avail(c));
                count_errors++;
            end
            assert (!rd_valid[c] || model_q[c].size() != 0) else begin
                $display("rd_valid high on channel %0d with no word stored", c);
                flow_errors++;
            end
            low_cycles[c] = (rd_valid[c] || model_q[c].size() == 0) ? 0 : low_cycles[c] + 1;
            assert (low_cycles[c] <= 2) else begin   // Two-cycle fetch latency
                $display("rd_valid still low on channel %0d two cycles after data arrived", c);
                flow_errors++;
            end
        end
        assert (wr_ready == (model_stored[wr_id] < sram_depth)) else begin
            $display("error wr_ready ch %0d: got 0x%0h expected 0x%0h",
                     wr_id, wr_ready, model_stored[wr_id] < sram_depth);
            count_errors++;
        end
    endtask

    // Model update for what the coming edge accepts
    task automatic apply_events();
        logic wf;
        logic pf;
        logic ag;
        logic dg;
        wr_fired = wr_valid && (model_stored[wr_id] < sram_depth);
        for (int c = 0; c < num_channels; c++) begin
            wf = wr_valid && (wr_id == c) && (model_stored[c] < sram_depth);
            pf = rd_drain && (rd_id == c);
            ag = alloc_req && (alloc_id == c) && (alloc_size <= model_space(c));
            dg = drain_req[c] && (drain_size[c] <= model_avail(c));
            if (pf) begin
                assert (rd_valid[c]) else begin
                    $display("drain on channel %0d found rd_valid low", c);
                    flow_errors++;
                end
                assert (rd_data == model_q[c][0]) else begin
                    $display("error rd_data ch %0d: got 0x%08h expected 0x%08h",
                             c, rd_data, model_q[c][0]);
                    data_errors++;
                end
                void'(model_q[c].pop_front());
            end
            if (wf) begin
                model_q[c].push_back(wr_data);
            end
            model_space_rsv[c] += ag ? int'(alloc_size) : 0;   // Grant first, then consume
            if (wf && model_space_rsv[c] > 0) begin
                model_space_rsv[c]--;
            end
            model_drain_rsv[c] += dg ? int'(drain_size[c]) : 0;
            if (pf && model_drain_rsv[c] > 0) begin
                model_drain_rsv[c]--;
            end
            model_stored[c] += int'(wf) - int'(pf);
        end
    endtask

    // Pick the next inputs, apply them at the rising edge
    task automatic drive_next(input int wr_pct, input int rd_pct,
                              input int alloc_pct, input int rsv_pct);
        logic                                    n_wr_valid;
        logic [chan_id_width-1:0]                n_wr_id;
        logic [data_width-1:0]                   n_wr_data;
        logic                                    n_rd_drain;
        logic [num_channels-1:0]                 n_drain_req;
        logic [num_channels-1:0][size_width-1:0] n_drain_size;
        int                                      c;
        if (wr_valid && !wr_fired) begin   // Source holds a stalled beat
            n_wr_valid = 1'b1;
            n_wr_id    = wr_id;
            n_wr_data  = wr_data;
        end else begin
            n_wr_valid = rand_below(100) < wr_pct;
            n_wr_id    = chan_id_width'(rand_below(num_channels));
            n_wr_data  = $random(seed);
        end
        c = rand_below(num_channels);
        // Only a channel still valid after this edge
        n_rd_drain = (rand_below(100) < rd_pct) && rd_valid[c] && !(rd_drain && rd_id == c);
        for (int i = 0; i < num_channels; i++) begin
            n_drain_req[i]  = rand_below(100) < rsv_pct;
            n_drain_size[i] = size_width'(rand_below(sram_depth + 3));   // Some too large
        end
        @(posedge clk);
        wr_valid   <= n_wr_valid;
        wr_id      <= n_wr_id;
        wr_data    <= n_wr_data;
        rd_drain   <= n_rd_drain;
        rd_id      <= chan_id_width'(c);
        alloc_req  <= rand_below(100) < alloc_pct;
        alloc_id   <= chan_id_width'(rand_below(num_channels));
        alloc_size <= size_width'(rand_below(sram_depth + 5));
        drain_req  <= n_drain_req;
        drain_size <= n_drain_size;
    endtask

    task automatic run_cycle(input int wr_pct, input int rd_pct,
                             input int alloc_pct, input int rsv_pct);
        @(negedge clk);
        check_outputs();
        apply_events();
        drive_next(wr_pct, rd_pct, alloc_pct, rsv_pct);
    endtask

    // Drain until rd_valid has stayed low for longer than the fetch latency
    task automatic flush_channels();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            quiet = (rd_valid == '0 && !wr_valid) ? quiet + 1 : 0;
            check_outputs();
            apply_events();
            drive_next(0, 100, 0, 0);
        end
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        seed         = 32'h5f64e93a;
        clk          = 1'b0;
        reset        = 1'b1;
        wr_valid     = 1'b0;
        wr_id        = '0;
        wr_data      = '0;
        alloc_req    = 1'b0;
        alloc_id     = '0;
        alloc_size   = '0;
        drain_req    = '0;
        drain_size   = '0;
        rd_drain     = 1'b0;
        rd_id        = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        // Reset state seen through every wr_id
        for (int i = 0; i < num_channels; i++) begin
            @(posedge clk);
            wr_id <= chan_id_width'(i);
            @(negedge clk);
            check_outputs();
            assert (rd_valid == '0) else begin
                $display("error rd_valid: got 0x%0h expected 0x0", rd_valid);
                count_errors++;
            end
        end

        repeat (fill_cycles) run_cycle(90, 20, 25, 15);
        repeat (mix_cycles) run_cycle(40, 80, 25, 15);
        while (reservations_open()) run_cycle(60, 60, 0, 0);   // Writes use up reservations
        flush_channels();
        repeat (4) run_cycle(0, 0, 0, 0);                      // rd_valid must stay low

        @(negedge clk);
        for (int c = 0; c < num_channels; c++) begin
            assert (model_q[c].size() == 0) else begin
                $display("channel %0d model still holds words after the flush", c);
                flow_errors++;
            end
            assert (int'(space_free[c]) == sram_depth) else begin
                $display("error space_free ch %0d: got 0x%0h expected 0x%0h",
                         c, space_free[c], sram_depth);
                count_errors++;
            end
        end

        checker_errors = dut.gen_channel[0].u_unit.u_checker.fail_count
                       + dut.gen_channel[1].u_unit.u_checker.fail_count
                       + dut.gen_channel[2].u_unit.u_checker.fail_count
                       + dut.gen_channel[3].u_unit.u_checker.fail_count;
        $display("data errors %0d, count errors %0d, flow errors %0d, assertion errors %0d",
                 data_errors, count_errors, flow_errors, checker_errors);
        if (data_errors + count_errors + flow_errors + checker_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_sram_controller

`default_nettype wire

// ==== verification/sram_controller_checker.sv ====
// ================================================
// Bound assertions on one buffer channel
// Full writes, empty valid, held word, reset
// ================================================

`timescale 1ns/1ps
`default_nettype none

module sram_controller_checker (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_ready,
    input  logic                                rd_valid,
    input  logic [stream_pkg::data_width-1:0]   rd_data,       // Bridge output register
    input  logic                                pop_fire,
    input  logic                                fifo_wr_en,
    input  logic [stream_pkg::count_width-1:0]  fifo_wr_ptr,   // FIFO pointers with wrap bit
    input  logic [stream_pkg::count_width-1:0]  fifo_rd_ptr,
    input  logic [stream_pkg::count_width-1:0]  stored_cnt,    // Tracker stored words
    input  logic [stream_pkg::count_width-1:0]  space_free,
    input  logic [stream_pkg::count_width-1:0]  data_avail
);

    import stream_pkg::*;

    int full_write_fails = 0;
    int empty_valid_fails = 0;
    int load_fails = 0;
    int reset_fails = 0;
    int fail_count;   // Read by the testbench report

    assign fail_count = full_write_fails + empty_valid_fails + load_fails + reset_fails;

    // ================================================
    // Properties
    // ================================================
    // Memory full when only the wrap bits differ
    no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        ((fifo_wr_ptr ^ fifo_rd_ptr) == count_width'(sram_depth)) |-> !fifo_wr_en)
        else begin
            $error("FIFO written while its memory is full");
            full_write_fails++;
        end

    no_valid_when_empty: assert property (@(posedge clk) disable iff (reset)
        $rose(rd_valid) |-> (stored_cnt != '0))
        else begin
            $error("rd_valid rose with no stored word");
            empty_valid_fails++;
        end

    // A held word stays in the register until it is taken
    no_load_over_word: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && !pop_fire) |=> (rd_valid && $stable(rd_data)))
        else begin
            $error("bridge register changed before its word was taken");
            load_fails++;
        end

    reset_values: assert property (@(posedge clk)
        $fell(reset) |-> (wr_ready && !rd_valid && data_avail == '0
                          && space_free == count_width'(sram_depth)))
        else begin
            $error("channel outputs wrong right after reset");
            reset_fails++;
        end

endmodule : sram_controller_checker

`default_nettype wire

// ==== rtl/sram_controller.sv ====
// ================================================
// Stream buffer controller top level
// Id decode, ready and data muxes, channel array
// ================================================

`timescale 1ns/1ps
`default_nettype none

module sram_controller (
    input  logic                                                       clk,
    input  logic                                                       reset,

    // ================================================
    // Write side, from the read engine
    // ================================================
    input  logic                                                       wr_valid,
    input  logic [stream_pkg::chan_id_width-1:0]                       wr_id,
    input  logic [stream_pkg::data_width-1:0]                          wr_data,   // Shared
    output logic                                                       wr_ready,  // Of wr_id

    // Space reservation
    input  logic                                                       alloc_req,
    input  logic [stream_pkg::chan_id_width-1:0]                       alloc_id,
    input  logic [stream_pkg::size_width-1:0]                          alloc_size,
    output logic [stream_pkg::num_channels-1:0][stream_pkg::count_width-1:0] space_free,

    // Data reservation, one request per channel
    input  logic [stream_pkg::num_channels-1:0]                        drain_req,
    input  logic [stream_pkg::num_channels-1:0][stream_pkg::size_width-1:0]  drain_size,
    output logic [stream_pkg::num_channels-1:0][stream_pkg::count_width-1:0] data_avail,

    // ================================================
    // Read side, toward the write engine
    // ================================================
    input  logic                                                       rd_drain,
    input  logic [stream_pkg::chan_id_width-1:0]                       rd_id,
    output logic [stream_pkg::num_channels-1:0]                        rd_valid,
    output logic [stream_pkg::data_width-1:0]                          rd_data    // Of rd_id
);

    import stream_pkg::*;

    logic [num_channels-1:0]                 wr_valid_sel;   // One-hot write strobe
    logic [num_channels-1:0]                 alloc_req_sel;  // One-hot allocation strobe
    logic [num_channels-1:0]                 rd_drain_sel;   // One-hot drain strobe
    logic [num_channels-1:0]                 chan_ready;
    logic [num_channels-1:0][data_width-1:0] chan_rd_data;

    // ================================================
    // Id decode
    // ================================================
    // Every two-bit id names a channel, no range check needed
    always_comb begin
        wr_valid_sel  = '0;
        alloc_req_sel = '0;
        rd_drain_sel  = '0;
        wr_valid_sel[wr_id]     = wr_valid;
        alloc_req_sel[alloc_id] = alloc_req;
        rd_drain_sel[rd_id]     = rd_drain;
    end

    // Muxes back to the shared ports
    assign wr_ready = chan_ready[wr_id];
    assign rd_data  = chan_rd_data[rd_id];   // Bridge register of rd_id

    // ================================================
    // Channel array
    // ================================================
    for (genvar i = 0; i < num_channels; i++) begin : gen_channel
        sram_channel_unit u_unit (
            .clk        (clk),
            .reset      (reset),
            .wr_valid   (wr_valid_sel[i]),
            .wr_ready   (chan_ready[i]),
            .wr_data    (wr_data),
            .alloc_req  (alloc_req_sel[i]),
            .alloc_size (alloc_size),         // Same size seen by all
            .space_free (space_free[i]),
            .drain_req  (drain_req[i]),
            .drain_size (drain_size[i]),
            .data_avail (data_avail[i]),
            .rd_drain   (rd_drain_sel[i]),
            .rd_valid   (rd_valid[i]),
            .rd_data    (chan_rd_data[i])
        );
    end

endmodule : sram_controller

`default_nettype wire

// ==== rtl/sram_channel_unit.sv ====
// ================================================
// One buffer channel
// Tracker, FIFO memory and latency bridge
// ================================================

`timescale 1ns/1ps
`default_nettype none

module sram_channel_unit (
    input  logic                                clk,
    input  logic                                reset,
    // Fill side
    input  logic                                wr_valid,
    output logic                                wr_ready,
    input  logic [stream_pkg::data_width-1:0]   wr_data,
    // Space reservation
    input  logic                                alloc_req,
    input  logic [stream_pkg::size_width-1:0]   alloc_size,
    output logic [stream_pkg::count_width-1:0]  space_free,
    // Data reservation
    input  logic                                drain_req,
    input  logic [stream_pkg::size_width-1:0]   drain_size,
    output logic [stream_pkg::count_width-1:0]  data_avail,
    // Drain side
    input  logic                                rd_drain,
    output logic                                rd_valid,
    output logic [stream_pkg::data_width-1:0]   rd_data
);

    import stream_pkg::*;

    logic                  wr_fire;        // Accepted write beat
    logic                  pop_fire;       // Accepted drain
    logic                  fifo_rd_en;
    logic                  fifo_empty;
    logic [data_width-1:0] fifo_rd_data;

    assign wr_fire  = wr_valid && wr_ready;
    assign pop_fire = rd_drain && rd_valid;   // Drain with no data is ignored

    // ================================================
    // Counters and flow control
    // ================================================
    alloc_tracker u_tracker (
        .clk        (clk),
        .reset      (reset),
        .wr_fire    (wr_fire),
        .pop_fire   (pop_fire),
        .alloc_req  (alloc_req),
        .alloc_size (alloc_size),
        .drain_req  (drain_req),
        .drain_size (drain_size),
        .ready      (wr_ready),
        .space_free (space_free),
        .data_avail (data_avail)
    );

    // Storage
    sram_channel_fifo u_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_fire),
        .wr_data (wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    // Head register toward the consumer
    latency_bridge u_bridge (
        .clk          (clk),
        .reset        (reset),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .pop          (pop_fire),
        .out_valid    (rd_valid),
        .out_data     (rd_data)
    );

endmodule : sram_channel_unit

`default_nettype wire

// ==== rtl/latency_bridge.sv ====
// ================================================
// Latency bridge between FIFO and consumer
// Keeps the head word in an output register
// ================================================

`timescale 1ns/1ps
`default_nettype none

module latency_bridge (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                fifo_empty,
    output logic                                fifo_rd_en,    // Fetch next word
    input  logic [stream_pkg::data_width-1:0]   fifo_rd_data,  // One cycle after fifo_rd_en
    input  logic                                pop,           // Consumer takes out_data
    output logic                                out_valid,
    output logic [stream_pkg::data_width-1:0]   out_data
);

    import stream_pkg::*;

    // ================================================
    // State
    // ================================================
    typedef enum logic [1:0] {
        idle     = 2'd0,   // Register empty, nothing fetched
        fetching = 2'd1,   // Register empty, fetch returning
        holding  = 2'd2    // Register full
    } bridge_state_t;

    bridge_state_t state;
    bridge_state_t state_next;
    logic          rd_pending;   // FIFO read port holds a word not yet loaded
    logic          load;         // Move read port word into out_data

    assign out_valid = (state == holding);

    // Load when a word is waiting and the register is or becomes free
    assign load = rd_pending && ((state != holding) || pop);

    // Fetch while the read port word is free or leaving this cycle
    // Allows one fetch ahead of a full register
    assign fifo_rd_en = !fifo_empty && (!rd_pending || load);

    // Next state logic
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (fifo_rd_en) begin
                    state_next = fetching;
                end
            end
            fetching: begin
                state_next = holding;   // Data returns, always loads
            end
            holding: begin
                if (pop && !load) begin
                    // Register empties; a new fetch may start now
                    state_next = fifo_rd_en ? fetching : idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    // ================================================
    // Registers
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            rd_pending <= 1'b0;
        end else begin
            state      <= state_next;
            rd_pending <= fifo_rd_en || (rd_pending && !load);
        end
    end

    // Output data register
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= fifo_rd_data;
        end
    end

endmodule : latency_bridge

`default_nettype wire

// ==== rtl/alloc_tracker.sv ====
// ================================================
// Allocation tracker for one channel
// Stored words, space and drain reservations
// ================================================

`timescale 1ns/1ps
`default_nettype none

module alloc_tracker (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_fire,      // Beat accepted into channel
    input  logic                                pop_fire,     // Beat drained from bridge
    input  logic                                alloc_req,    // Space reservation strobe
    input  logic [stream_pkg::size_width-1:0]   alloc_size,
    input  logic                                drain_req,    // Data reservation strobe
    input  logic [stream_pkg::size_width-1:0]   drain_size,
    output logic                                ready,        // Room for another beat
    output logic [stream_pkg::count_width-1:0]  space_free,
    output logic [stream_pkg::count_width-1:0]  data_avail
);

    import stream_pkg::*;

    // ================================================
    // Counters
    // ================================================
    logic [count_width-1:0] stored_cnt;    // FIFO plus bridge contents
    logic [count_width-1:0] space_rsv;     // Open space reservations
    logic [count_width-1:0] drain_rsv;     // Open drain reservations

    logic                   alloc_grant;
    logic                   drain_grant;
    logic [count_width-1:0] space_rsv_sum; // After this cycle's grant
    logic [count_width-1:0] drain_rsv_sum;

    // Reported values all come from the registered counters
    assign space_free = count_width'(sram_depth) - stored_cnt - space_rsv;
    assign data_avail = stored_cnt - drain_rsv;
    assign ready      = (stored_cnt < count_width'(sram_depth));

    // A request fits only within the current report
    assign alloc_grant = alloc_req && (alloc_size <= size_width'(space_free));
    assign drain_grant = drain_req && (drain_size <= size_width'(data_avail));

    // Granted sizes never exceed sram_depth, so truncation is exact
    assign space_rsv_sum = space_rsv + (alloc_grant ? count_width'(alloc_size) : '0);
    assign drain_rsv_sum = drain_rsv + (drain_grant ? count_width'(drain_size) : '0);

    // ================================================
    // Stored word count
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            stored_cnt <= '0;
        end else begin
            case ({wr_fire, pop_fire})
                2'b10:   stored_cnt <= stored_cnt + 1'b1;
                2'b01:   stored_cnt <= stored_cnt - 1'b1;
                default: stored_cnt <= stored_cnt;   // Both or neither
            endcase
        end
    end

    // ================================================
    // Reservations
    // ================================================
    // Each write consumes one reserved slot, floor at zero
    // A grant in the same cycle is consumed first, keeping free space >= 0
    always_ff @(posedge clk) begin
        if (reset) begin
            space_rsv <= '0;
        end else if (wr_fire && (space_rsv_sum != '0)) begin
            space_rsv <= space_rsv_sum - 1'b1;
        end else begin
            space_rsv <= space_rsv_sum;
        end
    end

    // Each drain consumes one reserved word, floor at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            drain_rsv <= '0;
        end else if (pop_fire && (drain_rsv_sum != '0)) begin
            drain_rsv <= drain_rsv_sum - 1'b1;
        end else begin
            drain_rsv <= drain_rsv_sum;
        end
    end

endmodule : alloc_tracker

`default_nettype wire

// ==== rtl/sram_channel_fifo.sv ====
// ================================================
// Per-channel FIFO memory
// Circular buffer with a registered read port
// ================================================

`timescale 1ns/1ps
`default_nettype none

module sram_channel_fifo (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_en,     // Push one beat
    input  logic [stream_pkg::data_width-1:0]   wr_data,
    input  logic                                rd_en,     // Fetch head into rd_data
    output logic [stream_pkg::data_width-1:0]   rd_data,   // Valid the cycle after rd_en
    output logic                                empty
);

    import stream_pkg::*;

    // ================================================
    // Storage and pointers
    // ================================================
    // Top pointer bit is the wrap bit, the rest is the address
    logic [data_width-1:0]  mem [sram_depth];
    logic [count_width-1:0] wr_ptr;
    logic [count_width-1:0] rd_ptr;

    // Same address and same wrap means nothing stored
    assign empty = (wr_ptr == rd_ptr);

    // Pointer update
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps naturally at 2*depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Write port
    // Overflow is ruled out upstream by the tracker's stored count
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[count_width-2:0]] <= wr_data;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr[count_width-2:0]];   // One cycle latency
        end
    end

endmodule : sram_channel_fifo

`default_nettype wire

// ==== rtl/stream_pkg.sv ====
// ================================================
// Shared sizes of the stream buffer controller
// Channel count, beat width, depth and count widths
// ================================================

`default_nettype none

package stream_pkg;

    // ================================================
    // Channel layout
    // ================================================
    localparam int num_channels  = 4;                        // Independent buffers
    localparam int chan_id_width = 2;                        // Covers every channel id

    // ================================================
    // Storage
    // ================================================
    localparam int data_width    = 32;                       // One beat
    localparam int sram_depth    = 16;                       // Words per channel
    localparam int count_width   = $clog2(sram_depth) + 1;   // Holds 0..sram_depth

    // Burst size carried by allocation and drain requests
    localparam int size_width    = 8;

endpackage : stream_pkg

`default_nettype wire
